/* project.f */
sram_pkg.sv
host_pkg.sv
bank_dispatch.sv
sram_bank_ctrl.sv
resp_collect.sv
sram_subsys.sv
sram_model.sv
sram_subsys_asserts.sv
tb_sram_subsys.sv

/* tb_sram_subsys.sv */
`timescale 1ns/1ps

module tb_sram_subsys
    import sram_pkg::*;
    import host_pkg::*;
();

    localparam int reset_cycles  = 10;
    localparam int clk_half      = 20;
    localparam int drive_dly     = 2;
    localparam int n_words       = 3;
    localparam int n_directed    = 2 * num_banks * n_words;
    localparam int n_random      = 200;
    localparam int n_total       = n_directed + n_random;
    localparam int ack_delay_max = 6;
    localparam int n_addr        = 1 << host_addr_w;
    // handshake, strobe and a fully delayed response for every request.
    localparam int timeout_cycles = reset_cycles + n_total * (4 + 2 * ack_delay_max);

    logic                             clk;
    logic                             rst_n;
    logic                             req;
    host_req_t                        req_data;
    logic                             req_ack;
    logic                             rsp;
    host_rsp_t                        rsp_data;
    logic                             rsp_ack;
    sram_pins_t [num_banks-1:0]       pins;
    logic [num_banks-1:0][data_w-1:0] din;

    logic [data_w-1:0]      shadow [n_addr];
    int                     outstanding [n_addr];
    host_req_t              pend_q [num_banks][$];
    int                     ack_delay [n_total];
    logic [word_addr_w-1:0] dir_word [n_words] = '{8'h00, 8'h5a, 8'hff};
    int                     req_cnt = 0;
    int                     rsp_cnt = 0;
    int                     errors = 0;
    int                     cycle_cnt = 0;

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    sram_subsys u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .req_ack  (req_ack),
        .rsp      (rsp),
        .rsp_data (rsp_data),
        .rsp_ack  (rsp_ack),
        .pins     (pins),
        .din      (din)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_chip
        sram_model #(.bank_idx(b)) u_chip (
            .pins (pins[b]),
            .din  (din[b])
        );
    end

    // same power-up pattern as the chip models.
    function automatic logic [data_w-1:0] fill_word(input int full_addr);
        return data_w'(full_addr * 16'h9e37 + 16'h1d2b);
    endfunction

    // one four-phase request, expected response queued first.
    task automatic send_req(input host_op_t op, input logic [host_addr_w-1:0] addr,
                            input logic [data_w-1:0] wdata);
        host_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        pend_q[addr[host_addr_w-1 -: bank_sel_w]].push_back(r);
        outstanding[addr]++;
        req_cnt++;
        req_data = r;
        req      = 1'b1;
        @(posedge clk);
        while (!req_ack)
            @(posedge clk);
        #drive_dly req = 1'b0;
        @(posedge clk);
        while (req_ack)
            @(posedge clk);
        #drive_dly;
    endtask

    // banks answer in order, so each response matches its bank's oldest request.
    task automatic check_rsp(input host_rsp_t r);
        host_req_t exp_r;
        int        b;
        b = int'(r.addr[host_addr_w-1 -: bank_sel_w]);
        rsp_cnt++;
        assert (pend_q[b].size() > 0 && outstanding[r.addr] > 0) else begin
            errors++;
            $display("response at %0t for address %h has no outstanding request", $time, r.addr);
        end
        if (outstanding[r.addr] > 0)
            outstanding[r.addr]--;
        if (pend_q[b].size() > 0) begin
            exp_r = pend_q[b].pop_front();
            assert (r.op == exp_r.op) else begin
                errors++;
                $display("ERR %0t rsp_data.op expected %0d got %0d", $time, exp_r.op, r.op);
            end
            assert (r.addr == exp_r.addr) else begin
                errors++;
                $display("ERR %0t rsp_data.addr expected %h got %h", $time, exp_r.addr, r.addr);
            end
            if (exp_r.op == op_write) begin
                assert (r.rdata == '0) else begin
                    errors++;
                    $display("ERR %0t rsp_data.rdata expected %h got %h", $time, 16'h0, r.rdata);
                end
                shadow[exp_r.addr] = exp_r.wdata;
            end else begin
                assert (r.rdata == shadow[exp_r.addr]) else begin
                    errors++;
                    $display("ERR %0t rsp_data.rdata expected %h got %h",
                             $time, shadow[exp_r.addr], r.rdata);
                end
            end
        end
    endtask

    // host side of the response channel, with random back-pressure.
    initial begin : rsp_side
        int dly;
        rsp_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rsp) begin
                dly = ack_delay[rsp_cnt % n_total];
                check_rsp(rsp_data);
                repeat (dly) @(posedge clk);
                #drive_dly rsp_ack = 1'b1;
                @(posedge clk);
                while (rsp)
                    @(posedge clk);
                #drive_dly rsp_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d of %0d responses back",
                 cycle_cnt, rsp_cnt, req_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : req_side
        host_op_t               op;
        logic [host_addr_w-1:0] a;
        void'($urandom(32'hb914));
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        for (int i = 0; i < n_addr; i++) begin
            shadow[i]      = fill_word(i);
            outstanding[i] = 0;
        end
        for (int i = 0; i < n_total; i++)
            ack_delay[i] = $urandom_range(ack_delay_max, 0);

        repeat (reset_cycles) @(posedge clk);
        #drive_dly rst_n = 1'b1;

        // write every bank, then read the same words back.
        for (int b = 0; b < num_banks; b++)
            for (int w = 0; w < n_words; w++)
                send_req(op_write, {bank_sel_w'(b), dir_word[w]}, data_w'($urandom));
        for (int b = 0; b < num_banks; b++)
            for (int w = 0; w < n_words; w++)
                send_req(op_read, {bank_sel_w'(b), dir_word[w]}, '0);

        // random mix, narrow word range so addresses repeat.
        for (int i = 0; i < n_random; i++) begin
            op = ($urandom_range(1, 0) == 1) ? op_write : op_read;
            a  = {bank_sel_w'($urandom_range(num_banks - 1, 0)),
                  word_addr_w'($urandom_range(31, 0))};
            send_req(op, a, data_w'($urandom));
        end

        while (rsp_cnt < req_cnt)
            @(posedge clk);
        repeat (4) @(posedge clk);

        for (int i = 0; i < n_addr; i++) begin
            assert (outstanding[i] == 0) else begin
                errors++;
                $display("%0d request(s) at address %h never answered", outstanding[i], i);
            end
        end

        $display("requests %0d, responses %0d, assertion failures %0d, check failures %0d",
                 req_cnt, rsp_cnt, u_dut.u_asserts.fail_cnt, errors);
        if (errors == 0 && u_dut.u_asserts.fail_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sram_subsys_asserts.sv */
`timescale 1ns/1ps

module sram_subsys_asserts
    import sram_pkg::*;
    import host_pkg::*;
(
    input logic                       clk,
    input logic                       rst_n,
    input logic                       req,
    input logic                       req_ack,
    input logic                       rsp,
    input host_rsp_t                  rsp_data,
    input logic                       rsp_ack,
    input sram_pins_t [num_banks-1:0] pins
);

    int fail_cnt = 0;

    logic [num_banks-1:0] ce_n_v;
    logic [num_banks-1:0] oe_n_v;
    logic [num_banks-1:0] we_n_v;
    logic [num_banks-1:0] den_v;

    // strobes of all chips side by side.
    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            ce_n_v[b] = pins[b].ce_n;
            oe_n_v[b] = pins[b].oe_n;
            we_n_v[b] = pins[b].we_n;
            den_v[b]  = pins[b].dout_en;
        end
    end

    // quiet outputs in reset and on the first edge after it.
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |->
            (!req_ack && !rsp && (&ce_n_v) && (&oe_n_v) && (&we_n_v) && (den_v == '0)))
    else begin
        $error("outputs not in their reset state around reset");
        fail_cnt++;
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_ack) |-> req)
    else begin
        $error("req_ack rose while req was low");
        fail_cnt++;
    end

    a_ack_falls_late: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req_ack) |-> !$past(req))
    else begin
        $error("req_ack fell before req was seen low");
        fail_cnt++;
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp && $past(rsp)) |-> $stable(rsp_data))
    else begin
        $error("rsp_data changed while rsp was high");
        fail_cnt++;
    end

    // rsp was launched on the previous edge, so rsp_ack must have been low there.
    a_rsp_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp) |-> !$past(rsp_ack))
    else begin
        $error("rsp rose while rsp_ack was still high");
        fail_cnt++;
    end

    // write and read strobes are exclusive and need the chip select.
    a_strobes: assert property (@(posedge clk) disable iff (!rst_n)
        (((~we_n_v) & (~oe_n_v)) == '0) && ((((~we_n_v) | (~oe_n_v)) & ce_n_v) == '0)
        && (den_v == ~we_n_v))
    else begin
        $error("chip strobe rule broken");
        fail_cnt++;
    end

endmodule

bind sram_subsys sram_subsys_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_ack  (req_ack),
    .rsp      (rsp),
    .rsp_data (rsp_data),
    .rsp_ack  (rsp_ack),
    .pins     (pins)
);

/* sram_model.sv */
`timescale 1ns/1ps

module sram_model
    import sram_pkg::*;
#(
    parameter int bank_idx = 0
)
(
    input  sram_pins_t        pins,
    output logic [data_w-1:0] din
);

    localparam int depth = 1 << word_addr_w;

    logic [data_w-1:0] mem [depth];

    // power-up content, a function of the full host address.
    initial begin
        for (int a = 0; a < depth; a++) begin
            mem[a] = data_w'((bank_idx * depth + a) * 16'h9e37 + 16'h1d2b);
        end
    end

    // level-sensitive write while the chip is selected and we_n is low.
    always @* begin
        if (!pins.ce_n && !pins.we_n)
            mem[pins.addr] = pins.dout;
    end

    // asynchronous read path.
    assign din = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr] : '0;

endmodule

/* sram_subsys.sv */
`timescale 1ns/1ps

module sram_subsys
    import sram_pkg::*;
    import host_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              req,
    input  host_req_t                         req_data,
    output logic                              req_ack,

    output logic                              rsp,
    output host_rsp_t                         rsp_data,
    input  logic                              rsp_ack,

    output sram_pins_t [num_banks-1:0]        pins,
    input  logic       [num_banks-1:0][data_w-1:0] din
);

    logic      [num_banks-1:0] idle;
    logic      [num_banks-1:0] start;
    bank_cmd_t                 cmd;

    logic      [num_banks-1:0] done;
    logic      [num_banks-1:0] take;
    host_rsp_t [num_banks-1:0] result;

    bank_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .req_ack  (req_ack),
        .idle     (idle),
        .start    (start),
        .cmd      (cmd)
    );

    // one controller per chip.
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        sram_bank_ctrl u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .start   (start[i]),
            .cmd     (cmd),
            .bank_id (bank_sel_w'(i)),
            .idle    (idle[i]),
            .done    (done[i]),
            .result  (result[i]),
            .take    (take[i]),
            .pins    (pins[i]),
            .din     (din[i])
        );
    end

    resp_collect u_collect (
        .clk      (clk),
        .rst_n    (rst_n),
        .done     (done),
        .result   (result),
        .take     (take),
        .rsp      (rsp),
        .rsp_data (rsp_data),
        .rsp_ack  (rsp_ack)
    );

endmodule

/* resp_collect.sv */
`timescale 1ns/1ps

module resp_collect
    import sram_pkg::*;
    import host_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic      [num_banks-1:0]     done,
    input  host_rsp_t [num_banks-1:0]     result,
    output logic      [num_banks-1:0]     take,

    output logic                          rsp,
    output host_rsp_t                     rsp_data,
    input  logic                          rsp_ack
);

    typedef enum logic [1:0] {
        c_idle = 2'b00,
        c_rsp  = 2'b01,
        c_drop = 2'b10
    } coll_state_t;

    coll_state_t state;

    logic [bank_sel_w-1:0] ptr;
    logic [bank_sel_w-1:0] pick;
    logic [bank_sel_w-1:0] idx;
    logic                  found;
    logic                  free;
    logic                  grant;

    // round-robin search, starting at ptr.
    always_comb begin
        found = 1'b0;
        pick  = ptr;
        idx   = ptr;
        for (int k = 0; k < num_banks; k++) begin
            idx = ptr + bank_sel_w'(k);
            if (!found && done[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // channel is free once the host has dropped rsp_ack.
    assign free  = (state == c_idle) || ((state == c_drop) && !rsp_ack);
    assign grant = free && found;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= c_idle;
            rsp   <= 1'b0;
            take  <= '0;
            ptr   <= '0;
        end else begin
            take <= '0;

            if (grant) begin
                take[pick] <= 1'b1;
                rsp        <= 1'b1;
                ptr        <= pick + 1'b1;
                state      <= c_rsp;
            end else begin
                case (state)
                    c_rsp: begin
                        if (rsp_ack) begin
                            rsp   <= 1'b0;
                            state <= c_drop;
                        end
                    end

                    c_drop: begin
                        if (!rsp_ack)
                            state <= c_idle;
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // response payload, held while rsp is up.
    always_ff @(posedge clk) begin
        if (grant)
            rsp_data <= result[pick];
    end

endmodule

/* sram_bank_ctrl.sv */
`timescale 1ns/1ps

module sram_bank_ctrl
    import sram_pkg::*;
    import host_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  start,
    input  bank_cmd_t             cmd,
    input  logic [bank_sel_w-1:0] bank_id,
    output logic                  idle,

    output logic                  done,
    output host_rsp_t             result,
    input  logic                  take,

    output sram_pins_t            pins,
    input  logic [data_w-1:0]     din
);

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_read  = 2'b01,
        st_write = 2'b10,
        st_done  = 2'b11
    } bank_state_t;

    bank_state_t state, state_nxt;

    logic                   latch_cmd;
    host_op_t               op_q;
    logic [word_addr_w-1:0] addr_q;
    logic [data_w-1:0]      wdata_q;
    logic [data_w-1:0]      rdata_q;

    assign latch_cmd = (state == st_idle) && start;

    // state register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // next state.
    always_comb begin
        state_nxt = state;

        case (state)
            st_idle: begin
                if (start)
                    state_nxt = (cmd.op == op_write) ? st_write : st_read;
            end

            st_read:  state_nxt = st_done;
            st_write: state_nxt = st_done;

            // result waits here until the collector takes it.
            st_done: begin
                if (take)
                    state_nxt = st_idle;
            end

            default: state_nxt = st_idle;
        endcase
    end

    // address, data and result latches.
    always_ff @(posedge clk) begin
        if (latch_cmd) begin
            op_q    <= cmd.op;
            addr_q  <= cmd.word_addr;
            wdata_q <= cmd.wdata;
        end

        // read data sampled at the end of the oe_n strobe
        if (state == st_read)
            rdata_q <= din;
        else if (state == st_write)
            rdata_q <= '0;
    end

    // chip strobes, Moore style.
    always_comb begin
        pins.ce_n    = 1'b1;
        pins.oe_n    = 1'b1;
        pins.we_n    = 1'b1;
        pins.dout_en = 1'b0;
        pins.addr    = addr_q;
        pins.dout    = wdata_q;

        case (state)
            st_read: begin
                pins.ce_n = 1'b0;
                pins.oe_n = 1'b0;
            end

            st_write: begin
                pins.ce_n    = 1'b0;
                pins.we_n    = 1'b0;
                pins.dout_en = 1'b1;
            end

            default: begin
            end
        endcase
    end

    // full address is rebuilt from the bank index.
    always_comb begin
        result.op    = op_q;
        result.addr  = {bank_id, addr_q};
        result.rdata = rdata_q;
    end

    assign idle = (state == st_idle);
    assign done = (state == st_done);

endmodule

/* bank_dispatch.sv */
`timescale 1ns/1ps

module bank_dispatch
    import sram_pkg::*;
    import host_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 req,
    input  host_req_t            req_data,
    output logic                 req_ack,

    input  logic [num_banks-1:0] idle,
    output logic [num_banks-1:0] start,
    output bank_cmd_t            cmd
);

    typedef enum logic [1:0] {
        d_wait  = 2'b00,
        d_start = 2'b01,
        d_ack   = 2'b10
    } disp_state_t;

    disp_state_t state;

    logic [bank_sel_w-1:0] req_bank;
    logic                  launch;

    // bank select sits in the top address bits.
    assign req_bank = req_data.addr[host_addr_w-1 -: bank_sel_w];

    // hand off only when the target bank reports idle.
    assign launch = (state == d_wait) && req && idle[req_bank];

    // handshake FSM.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= d_wait;
            start   <= '0;
            req_ack <= 1'b0;
        end else begin
            start <= '0;

            case (state)
                d_wait: begin
                    // a busy bank just holds the request here.
                    if (launch) begin
                        start[req_bank] <= 1'b1;
                        state           <= d_start;
                    end
                end

                d_start: begin
                    req_ack <= 1'b1;
                    state   <= d_ack;
                end

                d_ack: begin
                    // release once the host has dropped req.
                    if (!req) begin
                        req_ack <= 1'b0;
                        state   <= d_wait;
                    end
                end

                default: begin
                    state <= d_wait;
                end
            endcase
        end
    end

    // command register, shared by all banks.
    // only the bank that sees start picks it up.
    always_ff @(posedge clk) begin
        if (launch) begin
            cmd.op        <= req_data.op;
            cmd.word_addr <= req_data.addr[word_addr_w-1:0];
            cmd.wdata     <= req_data.wdata;
        end
    end

endmodule

/* host_pkg.sv */
package host_pkg;

    import sram_pkg::*;

    // full host address, bank select on top.
    localparam int host_addr_w = bank_sel_w + word_addr_w;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } host_op_t;

    // request as issued by the host.
    typedef struct packed {
        host_op_t               op;
        logic [host_addr_w-1:0] addr;
        logic [data_w-1:0]      wdata;
    } host_req_t;

    // request after bank decode.
    typedef struct packed {
        host_op_t               op;
        logic [word_addr_w-1:0] word_addr;
        logic [data_w-1:0]      wdata;
    } bank_cmd_t;

    // response back to the host, rdata is zero for writes.
    typedef struct packed {
        host_op_t               op;
        logic [host_addr_w-1:0] addr;
        logic [data_w-1:0]      rdata;
    } host_rsp_t;

endpackage

/* sram_pkg.sv */
package sram_pkg;

    // bank geometry.
    localparam int num_banks   = 4;
    localparam int bank_sel_w  = 2;
    localparam int word_addr_w = 8;
    localparam int data_w      = 16;

    // pins of one asynchronous SRAM chip.
    // strobes are active low, data out and data in are split,
    // and dout_en marks the cycles where dout is valid on the bus.
    typedef struct packed {
        logic                   ce_n;
        logic                   oe_n;
        logic                   we_n;
        logic [word_addr_w-1:0] addr;
        logic [data_w-1:0]      dout;
        logic                   dout_en;
    } sram_pins_t;

endpackage
